// ==== list.f ====
+incdir+test
src/calc_pkg.sv
src/key_input.sv
src/addsub_unit.sv
src/seq_multiplier.sv
src/calc_control.sv
src/calc_top.sv
test/tb_calc.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_calc
FILELIST  := list.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := ALL CHECKS PASSED

SRCS    := $(filter %.sv,$(shell cat $(FILELIST)))
HEADERS := $(wildcard test/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== test/tb_calc_tasks.svh ====
// Key press, idle and completion wait tasks plus the sign-magnitude reference model for tb_calc
`ifndef TB_CALC_TASKS_SVH
`define TB_CALC_TASKS_SVH

// Hold a key for some cycles, then release it for one
task automatic press_key(input key_code_t code, input int hold);
    @(posedge clk);
    key_code <= code;
    key_press <= 1'b1;
    repeat (hold) @(posedge clk);
    key_press <= 1'b0;
    @(posedge clk);
endtask

// Covers a times-ten step plus one key still queued behind it
task automatic idle_wait();
    repeat (IDLE_CYCLES) @(posedge clk);
endtask

task automatic enter_key(input key_code_t code);
    press_key(code, 3);
    idle_wait();
endtask

task automatic wait_complete(input string name);
    int cycles;
    cycles = 0;
    do begin
        @(negedge clk);
        cycles++;
    end while (completes_seen != equals_sent && cycles < DONE_TIMEOUT);
    if (completes_seen != equals_sent) begin
        timed_out = 1'b1;
        flow_errors++;
        $display("Timeout: no complete pulse within %0d cycles after equals in test %s",
                 DONE_TIMEOUT, name);
    end
endtask

function automatic int signed_val(input word_t x);
    int mag;
    mag = int'(x[calc_pkg::MAG_W-1:0]);
    return x[calc_pkg::DATA_W-1] ? -mag : mag;
endfunction

// Magnitude wraps mod 2^MAG_W, zero is always positive
function automatic word_t pack_sm(input int value);
    int mag;
    mag = (value < 0 ? -value : value) % (1 << calc_pkg::MAG_W);
    return {value < 0 && mag != 0, mag[calc_pkg::MAG_W-1:0]};
endfunction

function automatic word_t model_addsub(input word_t a, input word_t b, input bit sub);
    return pack_sm(sub ? signed_val(a) - signed_val(b) : signed_val(a) + signed_val(b));
endfunction

function automatic word_t model_mult(input word_t a, input word_t b);
    int prod;
    prod = int'(a[calc_pkg::MAG_W-1:0]) * int'(b[calc_pkg::MAG_W-1:0]);
    return pack_sm((a[calc_pkg::DATA_W-1] ^ b[calc_pkg::DATA_W-1]) ? -prod : prod);
endfunction

`endif

// ==== test/tb_calc.sv ====
// Testbench for the calculator core: key sequences in, assertions check every displayed result
`default_nettype none
`timescale 1ns/1ns

module tb_calc;

    typedef logic [calc_pkg::KEY_W-1:0] key_code_t;
    typedef logic [calc_pkg::DATA_W-1:0] word_t;

    localparam int IDLE_CYCLES = 2 * calc_pkg::MULT_LATENCY + 8;
    localparam int DONE_TIMEOUT = 4 * calc_pkg::MULT_LATENCY;
    localparam int RAND_RUNS = 30;

    logic      clk;
    logic      nRST;
    key_code_t key_code;
    logic      key_press;
    word_t     display_output;
    logic      complete;

    word_t expected = '0;
    string test_name = "reset";
    int    equals_sent = 0;
    int    completes_seen = 0;
    bit    timed_out = 1'b0;
    int    mismatch_errors = 0;
    int    idle_errors = 0;
    int    pulse_errors = 0;
    int    flow_errors = 0;

    calc_top DUT (
        .clk(clk), .nRST(nRST), .key_code(key_code), .key_press(key_press),
        .display_output(display_output), .complete(complete)
    );

    `include "tb_calc_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk or negedge nRST) begin
        if (!nRST)
            completes_seen <= 0;
        else if (complete)
            completes_seen <= completes_seen + 1;
    end

    result_check: assert property (
        @(posedge clk) disable iff (!nRST) complete |-> (display_output == expected)
    ) else begin
        mismatch_errors++;
        $display("ERR %s expected %h actual %h", test_name, expected,
                 $sampled(display_output));
    end

    // Nothing shows before the first equals
    idle_check: assert property (
        @(posedge clk) disable iff (!nRST)
        (equals_sent == 0) |-> (!complete && display_output == '0)
    ) else begin
        idle_errors++;
        $display("Output moved before the first equals press");
    end

    pulse_check: assert property (
        @(posedge clk) disable iff (!nRST) complete |-> (completes_seen < equals_sent)
    ) else begin
        pulse_errors++;
        $display("Extra complete pulse with no equals outstanding in test %s", test_name);
    end

    function automatic word_t operand_sm(input int value, input bit neg);
        return {neg, value[calc_pkg::MAG_W-1:0]};
    endfunction

    task automatic send_equals(input string name, input word_t value);
        @(posedge clk);
        test_name <= name;
        expected <= value;
        equals_sent <= equals_sent + 1;
        press_key(calc_pkg::KEY_EQUAL, 3);
        wait_complete(name);
    endtask

    // Digits most significant first, leading zeros included
    task automatic enter_number(input int value, input int ndig, input bit neg);
        int div;
        if (neg)
            enter_key(calc_pkg::KEY_NEG);
        div = 1;
        repeat (ndig - 1) div = div * 10;
        while (div > 0) begin
            enter_key(key_code_t'(value / div % 10));
            div = div / 10;
        end
    endtask

    task automatic run_calc(input string name, input int v1, input int n1, input bit neg1,
                            input key_code_t op_key, input int v2, input int n2,
                            input bit neg2);
        word_t a;
        word_t b;
        word_t exp;
        if (timed_out)
            return;
        a = operand_sm(v1, neg1);
        b = operand_sm(v2, neg2);
        case (op_key)
            calc_pkg::KEY_PLUS:  exp = model_addsub(a, b, 1'b0);
            calc_pkg::KEY_MINUS: exp = model_addsub(a, b, 1'b1);
            default:             exp = model_mult(a, b);
        endcase
        enter_number(v1, n1, neg1);
        enter_key(op_key);
        enter_number(v2, n2, neg2);
        send_equals(name, exp);
    endtask

    initial begin
        int        v1;
        int        v2;
        int        n1;
        int        n2;
        bit        g1;
        bit        g2;
        key_code_t op_key;
        int        total;

        void'($urandom(48));
        nRST = 1'b0;
        key_code = '0;
        key_press = 1'b0;
        repeat (5) @(posedge clk);
        nRST <= 1'b1;
        repeat (20) @(posedge clk);

        run_calc("add_multi_digit", 123, 3, 1'b0, calc_pkg::KEY_PLUS, 45, 2, 1'b0);
        run_calc("sub_negative", 45, 2, 1'b0, calc_pkg::KEY_MINUS, 123, 3, 1'b0);
        run_calc("sub_equal", 77, 2, 1'b0, calc_pkg::KEY_MINUS, 77, 2, 1'b0);
        run_calc("mul_one_neg", 12, 2, 1'b1, calc_pkg::KEY_TIMES, 34, 2, 1'b0);
        // 75000 wraps past 15 bits
        run_calc("mul_two_neg", 250, 3, 1'b1, calc_pkg::KEY_TIMES, 300, 3, 1'b1);

        for (int i = 0; i < RAND_RUNS; i++) begin
            n1 = 1 + int'($urandom % 3);
            n2 = 1 + int'($urandom % 3);
            v1 = int'($urandom % (n1 == 1 ? 10 : (n1 == 2 ? 100 : 1000)));
            v2 = int'($urandom % (n2 == 1 ? 10 : (n2 == 2 ? 100 : 1000)));
            g1 = ($urandom % 4) == 0;
            g2 = ($urandom % 4) == 0;
            case ($urandom % 3)
                0:       op_key = calc_pkg::KEY_PLUS;
                1:       op_key = calc_pkg::KEY_MINUS;
                default: op_key = calc_pkg::KEY_TIMES;
            endcase
            run_calc($sformatf("random_%0d", i), v1, n1, g1, op_key, v2, n2, g2);
        end

        if (!timed_out) begin
            // 3 arrives while 2 still waits behind the multiplier
            press_key(calc_pkg::KEY_1, 3);
            press_key(calc_pkg::KEY_2, 3);
            press_key(calc_pkg::KEY_3, 3);
            idle_wait();
            enter_key(calc_pkg::KEY_PLUS);
            // One long press is one digit
            press_key(calc_pkg::KEY_7, 40);
            idle_wait();
            send_equals("dropped_and_held",
                        model_addsub(operand_sm(12, 1'b0), operand_sm(7, 1'b0), 1'b0));
        end

        repeat (10) @(posedge clk);
        @(negedge clk);
        final_count: assert (completes_seen == equals_sent)
        else begin
            flow_errors++;
            $display("Saw %0d complete pulses for %0d equals presses",
                     completes_seen, equals_sent);
        end
        total = mismatch_errors + idle_errors + pulse_errors + flow_errors;
        $display("Errors: mismatch=%0d idle=%0d pulse=%0d flow=%0d, results %0d of %0d",
                 mismatch_errors, idle_errors, pulse_errors, flow_errors,
                 completes_seen, equals_sent);
        if (total == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/calc_top.sv ====
// Calculator core top level joining key input, controller and the two arithmetic units
`default_nettype none
`timescale 1ns/1ns

module calc_top (
    input  logic                        clk,
    input  logic                        nRST,
    input  logic [calc_pkg::KEY_W-1:0]  key_code,
    input  logic                        key_press,
    output logic [calc_pkg::DATA_W-1:0] display_output,
    output logic                        complete
);

    calc_pkg::key_event_t        key_event;
    logic                        read_input;
    logic                        key_read;
    calc_pkg::arith_req_t        add_req;
    logic                        start_add;
    logic [calc_pkg::DATA_W-1:0] add_result;
    logic                        add_finish;
    calc_pkg::arith_req_t        mult_req;
    logic                        start_mult;
    logic [calc_pkg::DATA_W-1:0] mult_result;
    logic                        mult_finish;

    key_input u_key_input (
        .clk(clk), .nRST(nRST),
        .key_code(key_code), .key_press(key_press), .key_read(key_read),
        .key_event(key_event), .read_input(read_input)
    );

    calc_control u_control (
        .clk(clk), .nRST(nRST),
        .key_event(key_event), .read_input(read_input), .key_read(key_read),
        .add_req(add_req), .start_add(start_add),
        .add_result(add_result), .add_finish(add_finish),
        .mult_req(mult_req), .start_mult(start_mult),
        .mult_result(mult_result), .mult_finish(mult_finish),
        .display_output(display_output), .complete(complete)
    );

    addsub_unit u_addsub (
        .clk(clk), .nRST(nRST), .req(add_req), .start(start_add),
        .result(add_result), .finish(add_finish)
    );

    // Busy is checked inside the multiplier, the controller only waits for finish
    seq_multiplier u_mult (
        .clk(clk), .nRST(nRST), .req(mult_req), .start(start_mult),
        .result(mult_result), .finish(mult_finish), .busy()
    );

endmodule

`default_nettype wire

// ==== src/calc_control.sv ====
// Calculator FSM: builds both operands from digit keys, dispatches on equals, shows the result
`default_nettype none
`timescale 1ns/1ns

module calc_control (
    input  logic                        clk,
    input  logic                        nRST,
    input  calc_pkg::key_event_t        key_event,
    input  logic                        read_input,
    output logic                        key_read,
    output calc_pkg::arith_req_t        add_req,
    output logic                        start_add,
    input  logic [calc_pkg::DATA_W-1:0] add_result,
    input  logic                        add_finish,
    output calc_pkg::arith_req_t        mult_req,
    output logic                        start_mult,
    input  logic [calc_pkg::DATA_W-1:0] mult_result,
    input  logic                        mult_finish,
    output logic [calc_pkg::DATA_W-1:0] display_output,
    output logic                        complete
);

    localparam int SIGN = calc_pkg::DATA_W - 1;
    localparam int MSB = calc_pkg::MAG_W - 1;

    calc_pkg::state_t             state;
    calc_pkg::state_t             next_state;
    calc_pkg::op_t                op_q;
    logic [calc_pkg::DATA_W-1:0]  operand1;
    logic [calc_pkg::DATA_W-1:0]  operand2;
    logic [calc_pkg::MAG_W-1:0]   digit_ext;
    logic [calc_pkg::KEY_W-1:0]   digit_q;
    logic                         arith_op;

    assign arith_op = key_event.op inside {calc_pkg::OP_ADD, calc_pkg::OP_SUB, calc_pkg::OP_MUL};
    assign digit_ext = {{(calc_pkg::MAG_W - calc_pkg::KEY_W){1'b0}}, digit_q};

    // Any pending key is taken in the two entry states, unused ones are dropped
    always_comb begin
        case (state)
            calc_pkg::WAIT_OP1, calc_pkg::WAIT_OP2:
                key_read = read_input || (key_event.op != calc_pkg::OP_NONE) || key_event.equal;
            default:
                key_read = 1'b0;
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            calc_pkg::WAIT_OP1: begin
                if (read_input)
                    next_state = calc_pkg::WAIT_MULT_OP1;
                else if (arith_op)
                    next_state = calc_pkg::WAIT_OP2;
            end
            calc_pkg::WAIT_MULT_OP1:
                if (mult_finish)
                    next_state = calc_pkg::ADD_KEY_INPUT_OP1;
            calc_pkg::ADD_KEY_INPUT_OP1:
                next_state = calc_pkg::WAIT_OP1;
            calc_pkg::WAIT_OP2: begin
                if (key_event.equal)
                    next_state = calc_pkg::SEND_TO_COMPUTE;
                else if (read_input)
                    next_state = calc_pkg::WAIT_MULT_OP2;
            end
            calc_pkg::WAIT_MULT_OP2:
                if (mult_finish)
                    next_state = calc_pkg::ADD_KEY_INPUT_OP2;
            calc_pkg::ADD_KEY_INPUT_OP2:
                next_state = calc_pkg::WAIT_OP2;
            calc_pkg::SEND_TO_COMPUTE:
                next_state = calc_pkg::WAIT_COMPUTE;
            calc_pkg::WAIT_COMPUTE: begin
                if (add_finish)
                    next_state = calc_pkg::SHOW_RESULT_ADDSUB;
                else if (mult_finish)
                    next_state = calc_pkg::SHOW_RESULT_MULT;
            end
            default:
                next_state = calc_pkg::WAIT_OP1;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state <= calc_pkg::WAIT_OP1;
            op_q <= calc_pkg::OP_NONE;
            operand1 <= '0;
            operand2 <= '0;
            digit_q <= '0;
            add_req <= '0;
            mult_req <= '0;
            start_add <= 1'b0;
            start_mult <= 1'b0;
            display_output <= '0;
            complete <= 1'b0;
        end else begin
            state <= next_state;
            start_add <= 1'b0;
            start_mult <= 1'b0;
            complete <= 1'b0;
            case (state)
                calc_pkg::WAIT_OP1: begin
                    if (read_input) begin
                        // Times ten on the magnitude, sign is put back afterwards
                        digit_q <= key_event.digit;
                        mult_req <= '{a: {1'b0, operand1[MSB:0]}, b: calc_pkg::DIGIT_BASE,
                                      sub: 1'b0};
                        start_mult <= 1'b1;
                    end else if (key_event.op == calc_pkg::OP_NEG) begin
                        operand1[SIGN] <= 1'b1;
                    end else if (arith_op) begin
                        op_q <= key_event.op;
                    end
                end
                calc_pkg::WAIT_MULT_OP1:
                    if (mult_finish)
                        operand1[MSB:0] <= mult_result[MSB:0];
                calc_pkg::ADD_KEY_INPUT_OP1:
                    operand1[MSB:0] <= operand1[MSB:0] + digit_ext;
                calc_pkg::WAIT_OP2: begin
                    if (read_input) begin
                        digit_q <= key_event.digit;
                        mult_req <= '{a: {1'b0, operand2[MSB:0]}, b: calc_pkg::DIGIT_BASE,
                                      sub: 1'b0};
                        start_mult <= 1'b1;
                    end else if (key_event.op == calc_pkg::OP_NEG) begin
                        operand2[SIGN] <= 1'b1;
                    end
                end
                calc_pkg::WAIT_MULT_OP2:
                    if (mult_finish)
                        operand2[MSB:0] <= mult_result[MSB:0];
                calc_pkg::ADD_KEY_INPUT_OP2:
                    operand2[MSB:0] <= operand2[MSB:0] + digit_ext;
                calc_pkg::SEND_TO_COMPUTE: begin
                    if (op_q == calc_pkg::OP_MUL) begin
                        mult_req <= '{a: operand1, b: operand2, sub: 1'b0};
                        start_mult <= 1'b1;
                    end else begin
                        add_req <= '{a: operand1, b: operand2, sub: op_q == calc_pkg::OP_SUB};
                        start_add <= 1'b1;
                    end
                end
                calc_pkg::WAIT_COMPUTE: begin
                    // Result goes out with complete right after finish
                    if (add_finish) begin
                        display_output <= add_result;
                        complete <= 1'b1;
                    end else if (mult_finish) begin
                        display_output <= mult_result;
                        complete <= 1'b1;
                    end
                end
                default: begin
                    operand1 <= '0;
                    operand2 <= '0;
                    op_q <= calc_pkg::OP_NONE;
                end
            endcase
        end
    end

    one_start: assert property (
        @(posedge clk) disable iff (!nRST) !(start_add && start_mult)
    );

    complete_pulse: assert property (
        @(posedge clk) disable iff (!nRST) complete |=> !complete
    );

endmodule

`default_nettype wire

// ==== src/seq_multiplier.sv ====
// Shift-and-add sign-magnitude multiplier, one magnitude bit per cycle, fixed latency
`default_nettype none
`timescale 1ns/1ns

module seq_multiplier (
    input  logic                        clk,
    input  logic                        nRST,
    input  calc_pkg::arith_req_t        req,
    input  logic                        start,
    output logic [calc_pkg::DATA_W-1:0] result,
    output logic                        finish,
    output logic                        busy
);

    logic [calc_pkg::MAG_W-1:0]      a_mag;
    logic [calc_pkg::MAG_W-1:0]      b_mag;
    logic [calc_pkg::MAG_W-1:0]      mcand;
    logic [calc_pkg::MAG_W-1:0]      mplier;
    logic [calc_pkg::MAG_W-1:0]      acc;
    logic [calc_pkg::MAG_W-1:0]      acc_next;
    logic                            sgn;
    logic [calc_pkg::MULT_CNT_W-1:0] count;

    assign a_mag = req.a[calc_pkg::MAG_W-1:0];
    assign b_mag = req.b[calc_pkg::MAG_W-1:0];
    assign busy = (count != '0);
    // Bits shifted past MAG_W are lost, so the product wraps
    assign acc_next = acc + (mplier[0] ? mcand : '0);

    // Bit 0 of b is handled at load, the rest in the busy cycles
    always_ff @(posedge clk) begin
        if (start) begin
            acc <= b_mag[0] ? a_mag : '0;
            mcand <= a_mag << 1;
            mplier <= b_mag >> 1;
            sgn <= req.a[calc_pkg::DATA_W-1] ^ req.b[calc_pkg::DATA_W-1];
        end else if (busy) begin
            acc <= acc_next;
            mcand <= mcand << 1;
            mplier <= mplier >> 1;
            if (count == 'd1)
                result <= {sgn && (acc_next != '0), acc_next};
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            count <= '0;
            finish <= 1'b0;
        end else begin
            finish <= busy && (count == 'd1);
            if (start)
                count <= calc_pkg::MULT_STEPS;
            else if (busy)
                count <= count - 'd1;
        end
    end

    // The controller has to wait for finish before the next start
    start_not_busy: assert property (
        @(posedge clk) disable iff (!nRST) start |-> !busy
    );

endmodule

`default_nettype wire

// ==== src/addsub_unit.sv ====
// Sign-magnitude adder/subtractor with a registered result, one cycle from start to finish
`default_nettype none
`timescale 1ns/1ns

module addsub_unit (
    input  logic                        clk,
    input  logic                        nRST,
    input  calc_pkg::arith_req_t        req,
    input  logic                        start,
    output logic [calc_pkg::DATA_W-1:0] result,
    output logic                        finish
);

    logic                       a_sign;
    logic                       b_sign;
    logic [calc_pkg::MAG_W-1:0] a_mag;
    logic [calc_pkg::MAG_W-1:0] b_mag;
    logic [calc_pkg::MAG_W-1:0] mag;
    logic                       sgn;

    assign a_sign = req.a[calc_pkg::DATA_W-1];
    assign a_mag = req.a[calc_pkg::MAG_W-1:0];
    assign b_mag = req.b[calc_pkg::MAG_W-1:0];
    // Subtraction is addition of b with its sign flipped
    assign b_sign = req.b[calc_pkg::DATA_W-1] ^ req.sub;

    always_comb begin
        if (a_sign == b_sign) begin
            mag = a_mag + b_mag;
            sgn = a_sign;
        end else if (a_mag >= b_mag) begin
            mag = a_mag - b_mag;
            sgn = a_sign;
        end else begin
            mag = b_mag - a_mag;
            sgn = b_sign;
        end
        // No negative zero
        if (mag == '0)
            sgn = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (start)
            result <= {sgn, mag};
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST)
            finish <= 1'b0;
        else
            finish <= start;
    end

endmodule

`default_nettype wire

// ==== src/key_input.sv ====
// Key front end: turns key presses into one held event that the controller acknowledges
`default_nettype none
`timescale 1ns/1ns

module key_input (
    input  logic                        clk,
    input  logic                        nRST,
    input  logic [calc_pkg::KEY_W-1:0]  key_code,
    input  logic                        key_press,
    input  logic                        key_read,
    output calc_pkg::key_event_t        key_event,
    output logic                        read_input
);

    logic                 press_d;
    logic                 press_rise;
    logic                 pending;
    logic                 dec_valid;
    logic                 dec_is_digit;
    calc_pkg::key_event_t dec_event;

    assign press_rise = key_press && !press_d;
    assign pending = read_input || (key_event.op != calc_pkg::OP_NONE) || key_event.equal;

    // Code to event decode, code 15 falls out as invalid
    always_comb begin
        dec_event.digit = key_code;
        dec_event.op = calc_pkg::OP_NONE;
        dec_event.equal = 1'b0;
        dec_is_digit = 1'b0;
        dec_valid = 1'b1;
        case (key_code)
            calc_pkg::KEY_PLUS:  dec_event.op = calc_pkg::OP_ADD;
            calc_pkg::KEY_MINUS: dec_event.op = calc_pkg::OP_SUB;
            calc_pkg::KEY_TIMES: dec_event.op = calc_pkg::OP_MUL;
            calc_pkg::KEY_NEG:   dec_event.op = calc_pkg::OP_NEG;
            calc_pkg::KEY_EQUAL: dec_event.equal = 1'b1;
            default: begin
                if (key_code <= calc_pkg::KEY_9)
                    dec_is_digit = 1'b1;
                else
                    dec_valid = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            press_d <= 1'b0;
            key_event <= '0;
            read_input <= 1'b0;
        end else begin
            press_d <= key_press;
            if (key_read) begin
                key_event.op <= calc_pkg::OP_NONE;
                key_event.equal <= 1'b0;
                read_input <= 1'b0;
            end else if (press_rise && !pending && dec_valid) begin
                // New presses are dropped while one is waiting
                key_event <= dec_event;
                read_input <= dec_is_digit;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/calc_pkg.sv ====
// Shared widths, key and operator codes, FSM states and bus structs for the calculator core
`default_nettype none

package calc_pkg;

    localparam int DATA_W = 16;
    localparam int MAG_W = 15;
    localparam int KEY_W = 4;
    localparam int OP_W = 3;
    localparam int MULT_LATENCY = 15;
    localparam int MULT_CNT_W = $clog2(MULT_LATENCY);
    // Shift-and-add steps left after the load cycle
    localparam logic [MULT_CNT_W-1:0] MULT_STEPS = MULT_CNT_W'(MULT_LATENCY - 1);
    localparam logic [DATA_W-1:0] DIGIT_BASE = 16'd10;

    localparam logic [KEY_W-1:0] KEY_0 = 4'd0;
    localparam logic [KEY_W-1:0] KEY_1 = 4'd1;
    localparam logic [KEY_W-1:0] KEY_2 = 4'd2;
    localparam logic [KEY_W-1:0] KEY_3 = 4'd3;
    localparam logic [KEY_W-1:0] KEY_4 = 4'd4;
    localparam logic [KEY_W-1:0] KEY_5 = 4'd5;
    localparam logic [KEY_W-1:0] KEY_6 = 4'd6;
    localparam logic [KEY_W-1:0] KEY_7 = 4'd7;
    localparam logic [KEY_W-1:0] KEY_8 = 4'd8;
    localparam logic [KEY_W-1:0] KEY_9 = 4'd9;
    localparam logic [KEY_W-1:0] KEY_PLUS = 4'd10;
    localparam logic [KEY_W-1:0] KEY_MINUS = 4'd11;
    localparam logic [KEY_W-1:0] KEY_TIMES = 4'd12;
    localparam logic [KEY_W-1:0] KEY_NEG = 4'd13;
    localparam logic [KEY_W-1:0] KEY_EQUAL = 4'd14;

    typedef enum logic [OP_W-1:0] {
        OP_NONE = 3'd0,
        OP_NEG  = 3'd1,
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_MUL  = 3'd4
    } op_t;

    typedef enum logic [3:0] {
        WAIT_OP1, WAIT_MULT_OP1, ADD_KEY_INPUT_OP1,
        WAIT_OP2, WAIT_MULT_OP2, ADD_KEY_INPUT_OP2,
        SEND_TO_COMPUTE, WAIT_COMPUTE,
        SHOW_RESULT_ADDSUB, SHOW_RESULT_MULT
    } state_t;

    typedef struct packed {
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic              sub;
    } arith_req_t;

    typedef struct packed {
        logic [KEY_W-1:0] digit;
        op_t              op;
        logic             equal;
    } key_event_t;

endpackage

`default_nettype wire
